// ==== mm_ram.f ====
+incdir+.
mm_ram_pkg.sv
mm_ram_decoder.sv
dp_ram.sv
sim_ctrl_regs.sv
irq_timer.sv
mm_ram_wrapper.sv
tb_mm_ram.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_mm_ram -f mm_ram.f > build.log 2>&1 \
    && ./obj_dir/Vtb_mm_ram > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "TEST FAIL" sim.log && exit 1 || exit 0

// ==== tb_mm_ram.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench of the memory-mapped RAM harness
//   plays the core on the instruction, data and interrupt ports
//   LFSR stimulus, reference memory model and a compare process
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "mm_ram_defines.svh"

module tb_mm_ram;

    logic                             clk_i;
    logic                             rst_i;
    logic                             instr_req_i;
    logic [31:0]                      instr_addr_i;
    logic                             instr_gnt_o;
    logic                             instr_rvalid_o;
    logic [`MM_INSTR_RDATA_WIDTH-1:0] instr_rdata_o;
    logic                             data_req_i;
    logic [31:0]                      data_addr_i;
    logic                             data_we_i;
    logic [3:0]                       data_be_i;
    logic [31:0]                      data_wdata_i;
    logic                             data_gnt_o;
    logic                             data_rvalid_o;
    logic [31:0]                      data_rdata_o;
    logic                             irq_o;
    logic [4:0]                       irq_id_o;
    logic                             irq_ack_i;
    logic [4:0]                       irq_id_i;
    logic                             print_valid_o;
    logic [7:0]                       print_char_o;
    logic                             tests_passed_o;
    logic                             tests_failed_o;
    logic                             exit_valid_o;
    logic [31:0]                      exit_value_o;

    // the test only touches the first 64 words of the RAM
    logic [31:0]                      ref_mem [64];
    logic [31:0]                      exp_rdata [$];
    bit                               exp_bound [$];
    logic [`MM_INSTR_RDATA_WIDTH-1:0] exp_line [$];
    logic [31:0]                      lfsr_q;
    logic [31:0]                      timer_max;
    logic [31:0]                      ref_exit;
    logic [31:0]                      prev_wdata;
    logic                             prev_req;
    logic                             prev_we;
    logic                             prev_instr_req;
    logic                             timer_active;
    mm_ram_pkg::target_e              cur_tgt;
    mm_ram_pkg::target_e              prev_tgt;
    mm_ram_pkg::target_e              exp_evt;
    mm_ram_pkg::target_e              obs_tgt;
    int                               n_pulse;

    mm_ram_wrapper u_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // Galois form, the bit shifted out toggles the tap positions
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'ha300_0000;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    function automatic logic [31:0] ref_merge(input logic [31:0] old, input logic [31:0] wd,
                                              input logic [3:0] be);
        logic [31:0] w;
        w = old;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                w[b*8 +: 8] = wd[b*8 +: 8];
            end
        end
        return w;
    endfunction

    // four words per aligned line, word 0 in the low bits
    function automatic logic [`MM_INSTR_RDATA_WIDTH-1:0] ref_line(input logic [31:0] addr);
        logic [`MM_INSTR_RDATA_WIDTH-1:0] line;
        line = '0;
        for (int i = 0; i < 4; i++) begin
            line[i*32 +: 32] = ref_mem[{addr[7:4], 2'(i)}];
        end
        return line;
    endfunction

    task automatic fail(input string msg);
        $display("error at %0t: %s", $time, msg);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic abort(input string why);
        $display("run stopped: %s", why);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            fail($sformatf("%s is %b, expected %b", what, got, exp));
        end
    endtask

    task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail($sformatf("%s is %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_word_max(input string what, input logic [31:0] got,
                                  input logic [31:0] max);
        if ($isunknown(got) || got > max) begin
            fail($sformatf("%s is %h, expected at most %h", what, got, max));
        end
    endtask

    task automatic check_line(input string what, input logic [`MM_INSTR_RDATA_WIDTH-1:0] got,
                              input logic [`MM_INSTR_RDATA_WIDTH-1:0] exp);
        if (got !== exp) begin
            fail($sformatf("%s is %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_target(input string what, input mm_ram_pkg::target_e got,
                                input mm_ram_pkg::target_e exp);
        if (got !== exp) begin
            fail($sformatf("%s shows %s, expected %s", what, got.name(), exp.name()));
        end
    endtask

    // one clock of stimulus, the reference model is updated as the request leaves
    task automatic drive(input logic d_req, input logic we, input logic [31:0] addr,
                         input logic [3:0] be, input logic [31:0] wd,
                         input mm_ram_pkg::target_e tgt, input logic i_req,
                         input logic [31:0] i_addr);
        @(posedge clk_i);
        if (i_req) begin
            exp_line.push_back(ref_line(i_addr));
        end
        if (d_req && !we) begin
            exp_bound.push_back(tgt == mm_ram_pkg::TGT_TIMER);
            if (tgt == mm_ram_pkg::TGT_RAM) begin
                exp_rdata.push_back(ref_mem[addr[7:2]]);
            end else if (tgt == mm_ram_pkg::TGT_TIMER) begin
                exp_rdata.push_back(timer_max);
            end else begin
                exp_rdata.push_back(32'h0);
            end
        end
        if (d_req && we && tgt == mm_ram_pkg::TGT_RAM) begin
            ref_mem[addr[7:2]] = ref_merge(ref_mem[addr[7:2]], wd, be);
        end
        instr_req_i  <= i_req;
        instr_addr_i <= i_addr;
        data_req_i   <= d_req;
        data_we_i    <= we;
        data_addr_i  <= addr;
        data_be_i    <= be;
        data_wdata_i <= wd;
        cur_tgt      <= tgt;
    endtask

    task automatic write(input logic [31:0] addr, input logic [3:0] be, input logic [31:0] wd,
                         input mm_ram_pkg::target_e tgt);
        drive(1'b1, 1'b1, addr, be, wd, tgt, 1'b0, 32'h0);
    endtask

    task automatic read(input logic [31:0] addr, input mm_ram_pkg::target_e tgt);
        drive(1'b1, 1'b0, addr, 4'hf, 32'h0, tgt, 1'b0, 32'h0);
    endtask

    task automatic idle(input int n);
        for (int i = 0; i < n; i++) begin
            drive(1'b0, 1'b0, 32'h0, 4'h0, 32'h0, mm_ram_pkg::TGT_NONE, 1'b0, 32'h0);
        end
    endtask

    task automatic ack_irq(input logic ack, input logic [4:0] id);
        @(posedge clk_i);
        irq_ack_i <= ack;
        irq_id_i  <= id;
    endtask

    // data reads and instruction fetches of the whole window in parallel
    task automatic readback_window();
        for (int w = 0; w < 64; w++) begin
            drive(1'b1, 1'b0, {24'h0, w[5:0], 2'b00}, 4'hf, 32'h0, mm_ram_pkg::TGT_RAM,
                  1'b1, {24'h0, w[5:0], 2'b00});
        end
    endtask

    // responses of the cycle before are checked while this cycle's request is stable
    always @(negedge clk_i) begin
        if (rst_i) begin
            prev_req       = 1'b0;
            prev_we        = 1'b0;
            prev_tgt       = mm_ram_pkg::TGT_NONE;
            prev_wdata     = 32'h0;
            prev_instr_req = 1'b0;
        end else begin
            check_bit("data grant", data_gnt_o, data_req_i);
            check_bit("data rvalid", data_rvalid_o, prev_req);
            if (data_rvalid_o && !prev_we) begin
                if (exp_rdata.size() == 0) begin
                    abort("data rvalid arrived without an outstanding read");
                end else if (exp_bound.pop_front()) begin
                    check_word_max("timer count", data_rdata_o, exp_rdata.pop_front());
                end else begin
                    check_word("data read", data_rdata_o, exp_rdata.pop_front());
                end
            end
            check_bit("instruction grant", instr_gnt_o, instr_req_i);
            check_bit("instruction rvalid", instr_rvalid_o, prev_instr_req);
            if (instr_rvalid_o) begin
                if (exp_line.size() == 0) begin
                    abort("instruction rvalid arrived without an outstanding fetch");
                end else begin
                    check_line("instruction line", instr_rdata_o, exp_line.pop_front());
                end
            end
            exp_evt = mm_ram_pkg::TGT_NONE;
            if (prev_req && prev_we && prev_tgt inside {mm_ram_pkg::TGT_PRINT,
                    mm_ram_pkg::TGT_PASS, mm_ram_pkg::TGT_FAIL, mm_ram_pkg::TGT_EXIT}) begin
                exp_evt = prev_tgt;
            end
            n_pulse = 0;
            obs_tgt = mm_ram_pkg::TGT_NONE;
            if (print_valid_o) begin
                n_pulse++;
                obs_tgt = mm_ram_pkg::TGT_PRINT;
            end
            if (tests_passed_o) begin
                n_pulse++;
                obs_tgt = mm_ram_pkg::TGT_PASS;
            end
            if (tests_failed_o) begin
                n_pulse++;
                obs_tgt = mm_ram_pkg::TGT_FAIL;
            end
            if (exit_valid_o) begin
                n_pulse++;
                obs_tgt = mm_ram_pkg::TGT_EXIT;
            end
            if (n_pulse > 1) begin
                abort("several control strobes were high in the same cycle");
            end
            check_target("control strobe", obs_tgt, exp_evt);
            if (exp_evt == mm_ram_pkg::TGT_PRINT) begin
                check_word("print char", {24'h0, print_char_o}, {24'h0, prev_wdata[7:0]});
            end
            if (exp_evt == mm_ram_pkg::TGT_EXIT) begin
                ref_exit = prev_wdata;
            end
            check_word("exit value", exit_value_o, ref_exit);
            if (!timer_active) begin
                check_bit("irq while the timer is idle", irq_o, 1'b0);
            end
            prev_req       = data_req_i;
            prev_we        = data_we_i;
            prev_tgt       = cur_tgt;
            prev_wdata     = data_wdata_i;
            prev_instr_req = instr_req_i;
        end
    end

    initial begin
        logic [31:0] v;
        logic [31:0] wd;
        logic [31:0] addr;
        logic [31:0] iaddr;
        logic        dreq;
        logic        we;
        logic        ireq;
        logic [3:0]  be;
        logic        got;
        int          n_load;
        int          edges;

        rst_i        = 1'b1;
        instr_req_i  = 1'b0;
        instr_addr_i = 32'h0;
        data_req_i   = 1'b0;
        data_addr_i  = 32'h0;
        data_we_i    = 1'b0;
        data_be_i    = 4'h0;
        data_wdata_i = 32'h0;
        irq_ack_i    = 1'b0;
        irq_id_i     = 5'd0;
        cur_tgt      = mm_ram_pkg::TGT_NONE;
        lfsr_q       = 32'h0ee98a29;
        timer_max    = 32'h0;
        ref_exit     = 32'h0;
        timer_active = 1'b0;
        repeat (10) @(posedge clk_i);
        rst_i <= 1'b0;

        // fill the window with a pattern of the whole byte address
        for (int w = 0; w < 64; w++) begin
            addr = {24'h0, w[5:0], 2'b00};
            write(addr, 4'hf, {addr[15:0] ^ 16'h3c5a, ~addr[15:0]}, mm_ram_pkg::TGT_RAM);
        end

        for (int k = 0; k < 200; k++) begin
            take_bits(1, v);
            dreq = v[0];
            take_bits(1, v);
            we = v[0];
            take_bits(6, v);
            addr = {24'h0, v[5:0], 2'b00};
            take_bits(4, v);
            be = v[3:0];
            take_bits(32, wd);
            take_bits(1, v);
            ireq = v[0];
            take_bits(6, v);
            iaddr = {24'h0, v[5:0], 2'b00};
            drive(dreq, we, addr, be, wd, mm_ram_pkg::TGT_RAM, ireq, iaddr);
        end
        readback_window();

        take_bits(8, v);
        write(`MM_PRINT_ADDR, 4'h1, {24'h0, v[7:0]}, mm_ram_pkg::TGT_PRINT);
        write(`MM_PRINT_ADDR, 4'hf, 32'h0000_0a21, mm_ram_pkg::TGT_PRINT);
        idle(2);
        write(`MM_PASS_ADDR, 4'hf, 32'h1, mm_ram_pkg::TGT_PASS);
        idle(1);
        write(`MM_FAIL_ADDR, 4'hf, 32'h1, mm_ram_pkg::TGT_FAIL);
        take_bits(32, v);
        write(`MM_EXIT_ADDR, 4'hf, v, mm_ram_pkg::TGT_EXIT);
        idle(5);
        read(`MM_PRINT_ADDR, mm_ram_pkg::TGT_PRINT);
        read(`MM_EXIT_ADDR, mm_ram_pkg::TGT_EXIT);
        take_bits(32, v);
        write(`MM_EXIT_ADDR, 4'hf, v, mm_ram_pkg::TGT_EXIT);
        idle(3);

        // unmapped space, including a word just above the RAM range
        for (int k = 0; k < 8; k++) begin
            take_bits(30, v);
            take_bits(32, wd);
            write({2'b01, v[29:0]}, 4'hf, wd, mm_ram_pkg::TGT_NONE);
            read({2'b01, v[29:0]}, mm_ram_pkg::TGT_NONE);
            take_bits(6, v);
            write({16'h0001, 8'h00, v[5:0], 2'b00}, 4'hf, wd, mm_ram_pkg::TGT_NONE);
        end
        readback_window();
        idle(2);

        take_bits(4, v);
        n_load = 4 + int'(v[3:0]);
        timer_max = n_load;
        timer_active = 1'b1;
        write(`MM_TIMER_ADDR, 4'hf, n_load, mm_ram_pkg::TGT_TIMER);
        read(`MM_TIMER_ADDR, mm_ram_pkg::TGT_TIMER);
        edges = 1;
        @(negedge clk_i);
        got = irq_o;
        while (!got && edges < n_load + 8) begin
            idle(1);
            edges++;
            @(negedge clk_i);
            got = irq_o;
        end
        if (!got) begin
            abort("the timer interrupt did not arrive");
        end
        check_word("timer interrupt delay", edges - 1, n_load);
        check_word("interrupt id", {27'h0, irq_id_o}, {27'h0, `MM_TIMER_IRQ_ID});
        ack_irq(1'b1, 5'd3);
        ack_irq(1'b1, `MM_TIMER_IRQ_ID);
        @(negedge clk_i);
        check_bit("irq after a foreign acknowledge", irq_o, 1'b1);
        ack_irq(1'b0, 5'd0);
        @(negedge clk_i);
        check_bit("irq after acknowledge", irq_o, 1'b0);
        timer_active = 1'b0;

        // a zero load in the last counting cycle stops the timer without an interrupt
        timer_max = 32'h0;
        write(`MM_TIMER_ADDR, 4'hf, 32'd3, mm_ram_pkg::TGT_TIMER);
        idle(2);
        write(`MM_TIMER_ADDR, 4'hf, 32'h0, mm_ram_pkg::TGT_TIMER);
        idle(12);
        read(`MM_TIMER_ADDR, mm_ram_pkg::TGT_TIMER);

        edges = 0;
        while ((exp_rdata.size() != 0 || exp_line.size() != 0) && edges < 20) begin
            idle(1);
            edges++;
        end
        @(negedge clk_i);
        if (exp_rdata.size() == 0 && exp_line.size() == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("responses still outstanding at the end of the run");
            $display("TEST FAIL");
            $fatal(1, "simulation stopped");
        end
    end

endmodule

// ==== mm_ram_wrapper.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top level of the memory-mapped RAM harness
//   core-side instruction, data and interrupt ports
//   data port decoder, two-port RAM, control registers and timer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "mm_ram_defines.svh"

module mm_ram_wrapper (
    input  logic                             clk_i,
    input  logic                             rst_i,

    input  logic                             instr_req_i,
    input  logic [31:0]                      instr_addr_i,
    output logic                             instr_gnt_o,
    output logic                             instr_rvalid_o,
    output logic [`MM_INSTR_RDATA_WIDTH-1:0] instr_rdata_o,

    input  logic                             data_req_i,
    input  logic [31:0]                      data_addr_i,
    input  logic                             data_we_i,
    input  logic [3:0]                       data_be_i,
    input  logic [31:0]                      data_wdata_i,
    output logic                             data_gnt_o,
    output logic                             data_rvalid_o,
    output logic [31:0]                      data_rdata_o,

    output logic                             irq_o,
    output logic [4:0]                       irq_id_o,
    input  logic                             irq_ack_i,
    input  logic [4:0]                       irq_id_i,

    output logic                             print_valid_o,
    output logic [7:0]                       print_char_o,
    output logic                             tests_passed_o,
    output logic                             tests_failed_o,
    output logic                             exit_valid_o,
    output logic [31:0]                      exit_value_o
);

    mm_ram_pkg::target_e target;
    logic                wr_en;
    logic                ram_req;
    logic                timer_load;
    logic [31:0]         ram_rdata;
    logic [31:0]         timer_count;

    // instruction fetches always hit the RAM, so only a grant and rvalid flop are needed
    assign instr_gnt_o = instr_req_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            instr_rvalid_o <= 1'b0;
        end else begin
            instr_rvalid_o <= instr_req_i;
        end
    end

    assign ram_req    = (target == mm_ram_pkg::TGT_RAM);
    assign timer_load = wr_en && (target == mm_ram_pkg::TGT_TIMER);

    mm_ram_decoder u_decoder (
        .clk_i         ( clk_i         ),
        .rst_i         ( rst_i         ),
        .data_req_i    ( data_req_i    ),
        .data_addr_i   ( data_addr_i   ),
        .data_we_i     ( data_we_i     ),
        .data_gnt_o    ( data_gnt_o    ),
        .data_rvalid_o ( data_rvalid_o ),
        .data_rdata_o  ( data_rdata_o  ),
        .ram_rdata_i   ( ram_rdata     ),
        .timer_count_i ( timer_count   ),
        .target_o      ( target        ),
        .wr_en_o       ( wr_en         )
    );

    dp_ram u_ram (
        .clk_i         ( clk_i                              ),
        .instr_req_i   ( instr_req_i                        ),
        .instr_addr_i  ( instr_addr_i[`MM_RAM_ADDR_WIDTH-1:0] ),
        .instr_rdata_o ( instr_rdata_o                      ),
        .data_req_i    ( ram_req                            ),
        .data_addr_i   ( data_addr_i                        ),
        .data_we_i     ( data_we_i                          ),
        .data_be_i     ( data_be_i                          ),
        .data_wdata_i  ( data_wdata_i                       ),
        .data_rdata_o  ( ram_rdata                          )
    );

    sim_ctrl_regs u_ctrl (
        .clk_i          ( clk_i          ),
        .rst_i          ( rst_i          ),
        .target_i       ( target         ),
        .wr_en_i        ( wr_en          ),
        .wdata_i        ( data_wdata_i   ),
        .print_valid_o  ( print_valid_o  ),
        .print_char_o   ( print_char_o   ),
        .tests_passed_o ( tests_passed_o ),
        .tests_failed_o ( tests_failed_o ),
        .exit_valid_o   ( exit_valid_o   ),
        .exit_value_o   ( exit_value_o   )
    );

    irq_timer u_timer (
        .clk_i        ( clk_i        ),
        .rst_i        ( rst_i        ),
        .load_i       ( timer_load   ),
        .load_value_i ( data_wdata_i ),
        .count_o      ( timer_count  ),
        .irq_o        ( irq_o        ),
        .irq_id_o     ( irq_id_o     ),
        .irq_ack_i    ( irq_ack_i    ),
        .irq_id_i     ( irq_id_i     )
    );

endmodule

// ==== irq_timer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Countdown timer with interrupt
//   loadable down-counter, read back as the remaining count
//   pending flag raised on expiry, cleared by a matching acknowledge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "mm_ram_defines.svh"

module irq_timer (
    input  logic        clk_i,
    input  logic        rst_i,

    input  logic        load_i,
    input  logic [31:0] load_value_i,
    output logic [31:0] count_o,

    output logic        irq_o,
    output logic [4:0]  irq_id_o,
    input  logic        irq_ack_i,
    input  logic [4:0]  irq_id_i
);

    logic [31:0] count_q;
    logic        expire;
    logic        ack_match;

    // a zero count means the timer is stopped
    assign expire    = !load_i && (count_q == 32'd1);
    assign ack_match = irq_ack_i && (irq_id_i == `MM_TIMER_IRQ_ID);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            count_q <= '0;
        end else if (load_i) begin
            count_q <= load_value_i;
        end else if (count_q != '0) begin
            count_q <= count_q - 32'd1;
        end
    end

    // a fresh expiry wins over an acknowledge of the previous one
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            irq_o <= 1'b0;
        end else if (expire) begin
            irq_o <= 1'b1;
        end else if (ack_match) begin
            irq_o <= 1'b0;
        end
    end

    assign count_o  = count_q;
    assign irq_id_o = `MM_TIMER_IRQ_ID;

    // the core acknowledges only an interrupt it has been offered
    assert property (@(posedge clk_i) disable iff (rst_i)
        irq_ack_i |-> irq_o);

endmodule

// ==== sim_ctrl_regs.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Simulation control registers
//   stdout character port
//   pass and fail strobes
//   exit value register with its valid strobe
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module sim_ctrl_regs (
    input  logic                clk_i,
    input  logic                rst_i,

    input  mm_ram_pkg::target_e target_i,
    input  logic                wr_en_i,
    input  logic [31:0]         wdata_i,

    output logic                print_valid_o,
    output logic [7:0]          print_char_o,
    output logic                tests_passed_o,
    output logic                tests_failed_o,
    output logic                exit_valid_o,
    output logic [31:0]         exit_value_o
);

    logic print_wr;
    logic pass_wr;
    logic fail_wr;
    logic exit_wr;

    assign print_wr = wr_en_i && (target_i == mm_ram_pkg::TGT_PRINT);
    assign pass_wr  = wr_en_i && (target_i == mm_ram_pkg::TGT_PASS);
    assign fail_wr  = wr_en_i && (target_i == mm_ram_pkg::TGT_FAIL);
    assign exit_wr  = wr_en_i && (target_i == mm_ram_pkg::TGT_EXIT);

    // each strobe lasts exactly one cycle after its write
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            print_valid_o  <= 1'b0;
            tests_passed_o <= 1'b0;
            tests_failed_o <= 1'b0;
            exit_valid_o   <= 1'b0;
            exit_value_o   <= '0;
        end else begin
            print_valid_o  <= print_wr;
            tests_passed_o <= pass_wr;
            tests_failed_o <= fail_wr;
            exit_valid_o   <= exit_wr;
            // the exit value stays until the program writes it again
            if (exit_wr) begin
                exit_value_o <= wdata_i;
            end
        end
    end

    // only the low byte of a print write is a character
    always_ff @(posedge clk_i) begin
        if (print_wr) begin
            print_char_o <= wdata_i[7:0];
        end
    end

    // a character or an exit value is always written as a known word
    assert property (@(posedge clk_i) disable iff (rst_i)
        (print_wr || exit_wr) |-> !$isunknown(wdata_i));

endmodule

// ==== dp_ram.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-port synchronous RAM
//   instruction port reads one aligned line of several words
//   data port reads or writes one word with byte enables
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "mm_ram_defines.svh"

module dp_ram (
    input  logic                             clk_i,

    input  logic                             instr_req_i,
    input  logic [`MM_RAM_ADDR_WIDTH-1:0]    instr_addr_i,
    output logic [`MM_INSTR_RDATA_WIDTH-1:0] instr_rdata_o,

    input  logic                             data_req_i,
    input  mm_ram_pkg::data_addr_u           data_addr_i,
    input  logic                             data_we_i,
    input  logic [3:0]                       data_be_i,
    input  logic [31:0]                      data_wdata_i,
    output logic [31:0]                      data_rdata_o
);

    localparam int WORD_AW        = `MM_RAM_ADDR_WIDTH - 2;
    localparam int DEPTH          = 2 ** WORD_AW;
    localparam int WORDS_PER_LINE = `MM_INSTR_RDATA_WIDTH / 32;
    localparam int LINE_SHIFT     = $clog2(WORDS_PER_LINE);

    logic [31:0]        mem [DEPTH];
    logic [WORD_AW-1:0] line_base;

    // first word of the aligned line holding the fetch address
    assign line_base = {instr_addr_i[`MM_RAM_ADDR_WIDTH-1:2+LINE_SHIFT], {LINE_SHIFT{1'b0}}};

    // word 0 of the line ends up in the low bits
    always_ff @(posedge clk_i) begin
        if (instr_req_i) begin
            for (int i = 0; i < WORDS_PER_LINE; i++) begin
                instr_rdata_o[i*32 +: 32] <= mem[line_base | WORD_AW'(i)];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (data_req_i) begin
            if (data_we_i) begin
                for (int b = 0; b < 4; b++) begin
                    if (data_be_i[b]) begin
                        mem[data_addr_i.ram.word_idx][b*8 +: 8] <= data_wdata_i[b*8 +: 8];
                    end
                end
            end else begin
                data_rdata_o <= mem[data_addr_i.ram.word_idx];
            end
        end
    end

endmodule

// ==== mm_ram_decoder.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data port control of the RAM harness
//   address decode into RAM or pseudo peripheral targets
//   immediate grant and one-cycle rvalid sequencing
//   read data selection from RAM, timer count or zero
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "mm_ram_defines.svh"

module mm_ram_decoder (
    input  logic                   clk_i,
    input  logic                   rst_i,

    input  logic                   data_req_i,
    input  mm_ram_pkg::data_addr_u data_addr_i,
    input  logic                   data_we_i,
    output logic                   data_gnt_o,
    output logic                   data_rvalid_o,
    output logic [31:0]            data_rdata_o,

    input  logic [31:0]            ram_rdata_i,
    input  logic [31:0]            timer_count_i,
    output mm_ram_pkg::target_e    target_o,
    output logic                   wr_en_o
);

    mm_ram_pkg::target_e target_q;
    logic                req_q;
    logic                we_q;

    // registers are word aligned, so the byte offset takes no part in the match
    function automatic logic is_reg(mm_ram_pkg::data_addr_u addr, logic [31:0] base);
        mm_ram_pkg::data_addr_u b;
        b = base;
        return (addr.periph.region == b.periph.region) &&
               (addr.periph.reg_idx == b.periph.reg_idx);
    endfunction

    // no back-pressure, every request is accepted in its own cycle
    assign data_gnt_o = data_req_i;
    assign wr_en_o    = data_req_i & data_we_i;

    always_comb begin
        target_o = mm_ram_pkg::TGT_NONE;
        if (data_req_i) begin
            if (data_addr_i.ram.unused == '0) begin
                target_o = mm_ram_pkg::TGT_RAM;
            end else if (is_reg(data_addr_i, `MM_PRINT_ADDR)) begin
                target_o = mm_ram_pkg::TGT_PRINT;
            end else if (is_reg(data_addr_i, `MM_PASS_ADDR)) begin
                target_o = mm_ram_pkg::TGT_PASS;
            end else if (is_reg(data_addr_i, `MM_FAIL_ADDR)) begin
                target_o = mm_ram_pkg::TGT_FAIL;
            end else if (is_reg(data_addr_i, `MM_EXIT_ADDR)) begin
                target_o = mm_ram_pkg::TGT_EXIT;
            end else if (is_reg(data_addr_i, `MM_TIMER_ADDR)) begin
                target_o = mm_ram_pkg::TGT_TIMER;
            end
        end
    end

    // one request in flight, answered in the following cycle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            req_q    <= 1'b0;
            we_q     <= 1'b0;
            target_q <= mm_ram_pkg::TGT_NONE;
        end else begin
            req_q    <= data_req_i;
            we_q     <= data_we_i;
            target_q <= target_o;
        end
    end

    assign data_rvalid_o = req_q;

    // writes and unmapped reads return zero
    always_comb begin
        data_rdata_o = '0;
        if (!we_q) begin
            case (target_q)
                mm_ram_pkg::TGT_RAM:   data_rdata_o = ram_rdata_i;
                mm_ram_pkg::TGT_TIMER: data_rdata_o = timer_count_i;
                default:               data_rdata_o = '0;
            endcase
        end
    end

    // a request from the core carries a known address and direction
    assert property (@(posedge clk_i) disable iff (rst_i)
        data_req_i |-> !$isunknown({data_addr_i, data_we_i}));

endmodule

// ==== mm_ram_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types of the memory-mapped RAM harness
//   data_addr_u  data port address with a RAM view and a peripheral view
//   target_e     decoded target of a data port request
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "mm_ram_defines.svh"

package mm_ram_pkg;

    // RAM view: anything above the RAM range must be zero for a RAM hit
    typedef struct packed {
        logic [31:`MM_RAM_ADDR_WIDTH]    unused;
        logic [`MM_RAM_ADDR_WIDTH-3:0]   word_idx;
        logic [1:0]                      byte_off;
    } ram_addr_t;

    // peripheral view: the top byte selects the region, the rest a register
    typedef struct packed {
        logic [7:0]  region;
        logic [21:0] reg_idx;
        logic [1:0]  byte_off;
    } periph_addr_t;

    // one data address word, decoded both ways
    typedef union packed {
        ram_addr_t    ram;
        periph_addr_t periph;
    } data_addr_u;

    typedef enum logic [2:0] {
        TGT_NONE,
        TGT_RAM,
        TGT_PRINT,
        TGT_PASS,
        TGT_FAIL,
        TGT_EXIT,
        TGT_TIMER
    } target_e;

endpackage

// ==== mm_ram_defines.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Build-time constants of the memory-mapped RAM harness
//   RAM size and instruction line width
//   pseudo peripheral base addresses
//   timer interrupt id and boot address
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef MM_RAM_DEFINES_SVH
`define MM_RAM_DEFINES_SVH

// byte address width of the RAM, 64 KiB by default
`define MM_RAM_ADDR_WIDTH    16

// width of one instruction fetch line
`define MM_INSTR_RDATA_WIDTH 128

// pseudo peripherals reached through the data port
`define MM_PRINT_ADDR        32'h1000_0000
`define MM_TIMER_ADDR        32'h1500_0000
`define MM_PASS_ADDR         32'h2000_0000
`define MM_FAIL_ADDR         32'h2000_0004
`define MM_EXIT_ADDR         32'h2000_000C

// interrupt line used by the countdown timer
`define MM_TIMER_IRQ_ID      5'd31

// first fetch address of a test program
`define MM_BOOT_ADDR         32'h0000_0080

`endif
